// File: all.f
verilog/cpu_pkg.sv
verilog/bus_pkg.sv
verilog/request_unit.sv
verilog/wb_master.sv
verilog/wb_sram.sv
verilog/mem_subsystem.sv
tb/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

dependencies: {}

sources:
  # packages first, then the design bottom up
  - files:
      - verilog/cpu_pkg.sv
      - verilog/bus_pkg.sv
      - verilog/request_unit.sv
      - verilog/wb_master.sv
      - verilog/wb_sram.sv
      - verilog/mem_subsystem.sv

  - target: test
    files:
      - tb/tb_mem_subsystem.sv

// File: tb/tb_mem_subsystem.sv
module tb_mem_subsystem;

    localparam int HIT_TIMEOUT = 50;   // cycles allowed per request
    localparam int HOLD_CYCLES = 20;   // window with en_i low
    localparam int N_WORDS     = 6;

    logic                     clk;
    logic                     rst;
    logic                     en_i;
    logic                     memread_i;
    logic                     memwrite_i;
    logic                     i_request_i;
    logic [cpu_pkg::XLEN-1:0] data_to_write_i;
    logic [cpu_pkg::XLEN-1:0] instruction_address_i;
    logic [cpu_pkg::XLEN-1:0] data_address_i;
    logic [cpu_pkg::XLEN-1:0] instruction_o;
    logic [cpu_pkg::XLEN-1:0] data_read_o;
    logic                     i_hit_o;
    logic                     d_hit_o;

    // reference copy of the sram contents
    logic [cpu_pkg::XLEN-1:0] model [bus_pkg::SRAM_WORDS];
    logic [cpu_pkg::XLEN-1:0] adr_list [$];   // addresses written so far
    int                       seed;
    int                       errors;
    int                       checks;

    mem_subsystem u_mem_subsystem (
        .clk                   (clk),
        .rst                   (rst),
        .en_i                  (en_i),
        .memread_i             (memread_i),
        .memwrite_i            (memwrite_i),
        .i_request_i           (i_request_i),
        .data_to_write_i       (data_to_write_i),
        .instruction_address_i (instruction_address_i),
        .data_address_i        (data_address_i),
        .instruction_o         (instruction_o),
        .data_read_o           (data_read_o),
        .i_hit_o               (i_hit_o),
        .d_hit_o               (d_hit_o)
    );

    always #4 clk = ~clk;

    // cpu address after the window offset
    function automatic bus_pkg::bus_adr_u to_bus(input logic [cpu_pkg::XLEN-1:0] cpu_adr);
        bus_pkg::bus_adr_u a;
        a.word = cpu_adr + bus_pkg::MEM_BASE;
        return a;
    endfunction

    function automatic bit in_window(input logic [cpu_pkg::XLEN-1:0] cpu_adr);
        bus_pkg::bus_adr_u a;
        a = to_bus(cpu_adr);
        return a.fields.region == bus_pkg::MEM_REGION;
    endfunction

    // word index, upper offset bits wrap around
    function automatic int word_of(input logic [cpu_pkg::XLEN-1:0] cpu_adr);
        bus_pkg::bus_adr_u a;
        a = to_bus(cpu_adr);
        return (a.fields.offset >> 2) % bus_pkg::SRAM_WORDS;
    endfunction

    function automatic logic [cpu_pkg::XLEN-1:0] expected_read(
        input logic [cpu_pkg::XLEN-1:0] cpu_adr
    );
        if (!in_window(cpu_adr)) begin
            return '0;   // outside the region reads as zero
        end
        return model[word_of(cpu_adr)];
    endfunction

    task automatic check_word(input string name, input logic [cpu_pkg::XLEN-1:0] act,
                              input logic [cpu_pkg::XLEN-1:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_hit(input bit instr, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < HIT_TIMEOUT) begin
            next_cycle();
            n++;
            if (i_hit_o || d_hit_o) begin
                ok = 1'b1;
            end
        end
        if (ok) begin
            check_bit("i_hit_o", i_hit_o, instr);
            check_bit("d_hit_o", d_hit_o, !instr);
        end else begin
            errors++;
            $display("Timeout at %0t: %s hit never arrived, request unit state %s",
                     $time, instr ? "instruction" : "data",
                     u_mem_subsystem.u_request_unit.state.name());
        end
    endtask

    // request already dropped, so no further pulse may show up
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_bit("i_hit_o", i_hit_o, 1'b0);
            check_bit("d_hit_o", d_hit_o, 1'b0);
        end
    endtask

    task automatic data_write(input logic [cpu_pkg::XLEN-1:0] adr,
                              input logic [cpu_pkg::XLEN-1:0] data);
        bit ok;
        memwrite_i      = 1'b1;
        data_address_i  = adr;
        data_to_write_i = data;
        wait_hit(1'b0, ok);
        memwrite_i = 1'b0;   // dropped in the hit cycle
        if (in_window(adr)) begin
            model[word_of(adr)] = data;
        end
        expect_quiet(3);
    endtask

    task automatic data_read(input logic [cpu_pkg::XLEN-1:0] adr);
        bit ok;
        memread_i      = 1'b1;
        data_address_i = adr;
        wait_hit(1'b0, ok);
        if (ok) begin
            check_word("data_read_o", data_read_o, expected_read(adr));
        end
        memread_i = 1'b0;
        expect_quiet(3);
    endtask

    task automatic fetch(input logic [cpu_pkg::XLEN-1:0] adr);
        logic [cpu_pkg::XLEN-1:0] held;
        bit                       ok;
        held                  = data_read_o;
        i_request_i           = 1'b1;
        instruction_address_i = adr;
        wait_hit(1'b1, ok);
        if (ok) begin
            check_word("instruction_o", instruction_o, expected_read(adr));
        end
        check_word("data_read_o", data_read_o, held);   // fetch leaves data side alone
        i_request_i = 1'b0;
        expect_quiet(3);
    endtask

    task automatic test_reset();
        check_bit("i_hit_o", i_hit_o, 1'b0);
        check_bit("d_hit_o", d_hit_o, 1'b0);
        check_word("instruction_o", instruction_o, '0);
        check_word("data_read_o", data_read_o, '0);
    endtask

    task automatic test_round_trip();
        logic [cpu_pkg::XLEN-1:0] adr;
        for (int i = 0; i < N_WORDS; i++) begin
            adr = ($random(seed) & 32'h0000_00ff) << 2;
            adr_list.push_back(adr);
            data_write(adr, $random(seed));
        end
        foreach (adr_list[i]) begin
            data_read(adr_list[i]);
        end
    endtask

    task automatic test_fetch();
        foreach (adr_list[i]) begin
            fetch(adr_list[i]);
        end
    endtask

    task automatic test_priority();
        logic [cpu_pkg::XLEN-1:0] adr;
        logic [cpu_pkg::XLEN-1:0] data;
        bit                       ok;
        adr                   = 32'h0000_0040;
        data                  = $random(seed);
        memwrite_i            = 1'b1;
        memread_i             = 1'b1;
        i_request_i           = 1'b1;
        data_address_i        = adr;
        instruction_address_i = adr;
        data_to_write_i       = data;
        wait_hit(1'b0, ok);   // write goes first
        memwrite_i          = 1'b0;
        model[word_of(adr)] = data;
        wait_hit(1'b0, ok);
        if (ok) begin
            check_word("data_read_o", data_read_o, expected_read(adr));
        end
        memread_i = 1'b0;
        wait_hit(1'b1, ok);   // fetch last
        if (ok) begin
            check_word("instruction_o", instruction_o, expected_read(adr));
        end
        i_request_i = 1'b0;
        expect_quiet(3);
    endtask

    task automatic test_out_of_window();
        logic [cpu_pkg::XLEN-1:0] in_adr;
        logic [cpu_pkg::XLEN-1:0] out_adr;
        in_adr  = 32'h0000_0010;
        out_adr = in_adr + 32'h0100_0000;   // region byte one past the sram
        data_write(in_adr, $random(seed));
        data_write(out_adr, $random(seed));
        data_read(out_adr);
        data_read(in_adr);   // same word index, must be untouched
    endtask

    task automatic test_enable_hold();
        logic [cpu_pkg::XLEN-1:0] adr;
        int                       hits;
        bit                       ok;
        adr            = adr_list[0];
        hits           = 0;
        en_i           = 1'b0;
        memread_i      = 1'b1;
        data_address_i = adr;
        repeat (HOLD_CYCLES) begin
            next_cycle();
            if (d_hit_o || i_hit_o) begin
                hits++;
            end
        end
        checks++;
        if (hits != 0) begin
            errors++;
            $display("At %0t a hit arrived although en_i was held low", $time);
        end
        en_i = 1'b1;
        wait_hit(1'b0, ok);
        if (ok) begin
            check_word("data_read_o", data_read_o, expected_read(adr));
        end
        memread_i = 1'b0;
        expect_quiet(3);
    endtask

    initial begin
        seed                  = 37;
        errors                = 0;
        checks                = 0;
        clk                   = 1'b0;
        rst                   = 1'b1;
        en_i                  = 1'b1;
        memread_i             = 1'b0;
        memwrite_i            = 1'b0;
        i_request_i           = 1'b0;
        data_to_write_i       = '0;
        instruction_address_i = '0;
        data_address_i        = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_round_trip();
        test_fetch();
        test_priority();
        test_out_of_window();
        test_enable_hold();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog/mem_subsystem.sv
module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en_i,
    input  logic                       memread_i,
    input  logic                       memwrite_i,
    input  logic                       i_request_i,
    input  logic [cpu_pkg::XLEN-1:0]   data_to_write_i,
    input  logic [cpu_pkg::XLEN-1:0]   instruction_address_i,
    input  logic [cpu_pkg::XLEN-1:0]   data_address_i,
    output logic [cpu_pkg::XLEN-1:0]   instruction_o,
    output logic [cpu_pkg::XLEN-1:0]   data_read_o,
    output logic                       i_hit_o,
    output logic                       d_hit_o
);

    // request unit <-> master
    logic                     bus_read;
    logic                     bus_write;
    bus_pkg::bus_adr_u        bus_adr;
    logic [cpu_pkg::XLEN-1:0] bus_wdat;
    logic                     bus_busy;
    logic [cpu_pkg::XLEN-1:0] bus_rdat;

    // master <-> sram
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    bus_pkg::bus_adr_u        wb_adr;
    logic [cpu_pkg::XLEN-1:0] wb_wdat;
    logic                     wb_ack;
    logic [cpu_pkg::XLEN-1:0] wb_rdat;

    request_unit u_request_unit (
        .clk                   (clk),
        .rst                   (rst),
        .en_i                  (en_i),
        .memread_i             (memread_i),
        .memwrite_i            (memwrite_i),
        .i_request_i           (i_request_i),
        .data_to_write_i       (data_to_write_i),
        .instruction_address_i (instruction_address_i),
        .data_address_i        (data_address_i),
        .busy_i                (bus_busy),
        .rdat_i                (bus_rdat),
        .read_o                (bus_read),
        .write_o               (bus_write),
        .adr_o                 (bus_adr),
        .wdat_o                (bus_wdat),
        .instruction_o         (instruction_o),
        .data_read_o           (data_read_o),
        .i_hit_o               (i_hit_o),
        .d_hit_o               (d_hit_o)
    );

    wb_master u_wb_master (
        .clk      (clk),
        .rst      (rst),
        .read_i   (bus_read),
        .write_i  (bus_write),
        .adr_i    (bus_adr),
        .wdat_i   (bus_wdat),
        .busy_o   (bus_busy),
        .rdat_o   (bus_rdat),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_wdat),
        .wb_ack_i (wb_ack),
        .wb_dat_i (wb_rdat)
    );

    wb_sram u_wb_sram (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_rdat)
    );

endmodule

// File: verilog/wb_sram.sv
module wb_sram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  bus_pkg::bus_adr_u          wb_adr_i,
    input  logic [cpu_pkg::XLEN-1:0]   wb_dat_i,
    output logic                       wb_ack_o,
    output logic [cpu_pkg::XLEN-1:0]   wb_dat_o
);

    logic [cpu_pkg::XLEN-1:0]    mem [bus_pkg::SRAM_WORDS];
    logic [bus_pkg::WAIT_W-1:0]  wait_cnt;
    logic [bus_pkg::SRAM_AW-1:0] word_idx;
    logic                        in_region;
    logic                        req;
    logic                        fire;     // last wait cycle, ack on this edge

    // byte address to word index, upper offset bits alias
    assign word_idx  = wb_adr_i.fields.offset[bus_pkg::SRAM_AW+1:2];
    assign in_region = (wb_adr_i.fields.region == bus_pkg::MEM_REGION);

    // no new count while the ack is still out
    assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign fire = req && (wait_cnt == bus_pkg::WAIT_W'(bus_pkg::SRAM_WAIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= fire;   // one cycle pulse
            if (fire) begin
                wait_cnt <= '0;
                if (!wb_we_i) begin
                    wb_dat_o <= in_region ? mem[word_idx] : '0;
                end
            end else if (req) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // array itself, outside the window a write just vanishes
    always_ff @(posedge clk) begin
        if (fire && wb_we_i && in_region) begin
            mem[word_idx] <= wb_dat_i;
        end
    end

endmodule

// File: verilog/wb_master.sv
module wb_master (
    input  logic                       clk,
    input  logic                       rst,
    // request side
    input  logic                       read_i,
    input  logic                       write_i,
    input  bus_pkg::bus_adr_u          adr_i,
    input  logic [cpu_pkg::XLEN-1:0]   wdat_i,
    output logic                       busy_o,
    output logic [cpu_pkg::XLEN-1:0]   rdat_o,
    // wishbone side
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output bus_pkg::bus_adr_u          wb_adr_o,
    output logic [cpu_pkg::XLEN-1:0]   wb_dat_o,
    input  logic                       wb_ack_i,
    input  logic [cpu_pkg::XLEN-1:0]   wb_dat_i
);

    logic entry_valid;   // request held on the bus
    logic entry_we;
    logic start;         // strobe that finds the entry free

    assign start = (read_i | write_i) & ~entry_valid;

    // control part of the single entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= 1'b0;
            entry_we    <= 1'b0;
        end else if (start) begin
            entry_valid <= 1'b1;
            entry_we    <= write_i;   // write wins if both show up
        end else if (entry_valid && wb_ack_i) begin
            entry_valid <= 1'b0;
            entry_we    <= 1'b0;
        end
    end

    // address and write data of the entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_adr_o <= '0;
            wb_dat_o <= '0;
        end else if (start) begin
            wb_adr_o.word <= adr_i.word;
            wb_dat_o      <= wdat_i;
        end
    end

    // read word stays put until the next read completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdat_o <= '0;
        end else if (entry_valid && wb_ack_i && !entry_we) begin
            rdat_o <= wb_dat_i;
        end
    end

    // classic single master, cyc and stb move together
    assign wb_cyc_o = entry_valid;
    assign wb_stb_o = entry_valid;
    assign wb_we_o  = entry_we;

    // busy covers the whole bus cycle
    assign busy_o = entry_valid;

endmodule

// File: verilog/request_unit.sv
module request_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en_i,
    input  logic                       memread_i,
    input  logic                       memwrite_i,
    input  logic                       i_request_i,
    input  logic [cpu_pkg::XLEN-1:0]   data_to_write_i,
    input  logic [cpu_pkg::XLEN-1:0]   instruction_address_i,  // pc
    input  logic [cpu_pkg::XLEN-1:0]   data_address_i,         // alu result
    input  logic                       busy_i,
    input  logic [cpu_pkg::XLEN-1:0]   rdat_i,
    output logic                       read_o,
    output logic                       write_o,
    output bus_pkg::bus_adr_u          adr_o,
    output logic [cpu_pkg::XLEN-1:0]   wdat_o,
    output logic [cpu_pkg::XLEN-1:0]   instruction_o,
    output logic [cpu_pkg::XLEN-1:0]   data_read_o,
    output logic                       i_hit_o,
    output logic                       d_hit_o
);

    cpu_pkg::req_state_t state, next_state;

    logic                     next_read;
    logic                     next_write;
    bus_pkg::bus_adr_u        next_adr;
    logic [cpu_pkg::XLEN-1:0] next_wdat;
    logic [cpu_pkg::XLEN-1:0] next_instruction;
    logic [cpu_pkg::XLEN-1:0] next_data_read;
    logic                     next_i_hit;
    logic                     next_d_hit;
    logic                     prev_busy;     // busy_i one cycle ago
    logic                     hit_pending;   // hit pulse still out to the cpu

    // the cpu updates its request lines during a hit cycle,
    // so nothing new is taken until the pulse is gone
    assign hit_pending = d_hit_o | i_hit_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= cpu_pkg::idle;
            read_o        <= 1'b0;
            write_o       <= 1'b0;
            adr_o         <= '0;
            wdat_o        <= '0;
            instruction_o <= '0;
            data_read_o   <= '0;
            i_hit_o       <= 1'b0;
            d_hit_o       <= 1'b0;
            prev_busy     <= 1'b0;
        end else if (en_i) begin   // stall holds everything
            state         <= next_state;
            read_o        <= next_read;
            write_o       <= next_write;
            adr_o         <= next_adr;
            wdat_o        <= next_wdat;
            instruction_o <= next_instruction;
            data_read_o   <= next_data_read;
            i_hit_o       <= next_i_hit;
            d_hit_o       <= next_d_hit;
            prev_busy     <= busy_i;
        end
    end

    always_comb begin
        next_state       = state;
        next_read        = 1'b0;    // strobes are single cycle
        next_write       = 1'b0;
        next_adr         = adr_o;
        next_wdat        = wdat_o;
        next_instruction = instruction_o;
        next_data_read   = data_read_o;
        next_i_hit       = 1'b0;
        next_d_hit       = 1'b0;

        case (state)
            cpu_pkg::idle: begin
                // write beats read beats fetch
                if (memwrite_i && !hit_pending) begin
                    next_state    = cpu_pkg::wait_write;
                    next_write    = 1'b1;
                    next_adr.word = data_address_i + bus_pkg::MEM_BASE;
                    next_wdat     = data_to_write_i;
                end else if (memread_i && !hit_pending) begin
                    next_state    = cpu_pkg::wait_read;
                    next_read     = 1'b1;
                    next_adr.word = data_address_i + bus_pkg::MEM_BASE;
                    next_wdat     = '0;
                end else if (i_request_i && !hit_pending) begin
                    next_state    = cpu_pkg::wait_instr;
                    next_read     = 1'b1;
                    next_adr.word = instruction_address_i + bus_pkg::MEM_BASE;
                    next_wdat     = '0;
                end
            end

            // one dead cycle so busy has time to rise
            cpu_pkg::wait_write: next_state = cpu_pkg::mem_write;
            cpu_pkg::wait_read:  next_state = cpu_pkg::mem_read;
            cpu_pkg::wait_instr: next_state = cpu_pkg::instr_read;

            cpu_pkg::mem_write: begin
                if (!busy_i) begin
                    next_state = cpu_pkg::idle;
                    next_d_hit = 1'b1;
                    next_adr   = '0;
                    next_wdat  = '0;
                end
            end

            cpu_pkg::mem_read: begin
                if (!busy_i) begin
                    next_state     = cpu_pkg::idle;
                    next_d_hit     = 1'b1;
                    next_data_read = rdat_i;    // master holds the word now
                    next_adr       = '0;
                end
            end

            cpu_pkg::instr_read: begin
                // only a falling busy counts as done
                if (!busy_i && prev_busy) begin
                    next_state       = cpu_pkg::idle;
                    next_i_hit       = 1'b1;
                    next_instruction = rdat_i;
                    next_adr         = '0;
                end
            end

            default: next_state = cpu_pkg::idle;
        endcase
    end

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

    // cpu addresses are shifted into this window before they hit the bus
    localparam logic [31:0] MEM_BASE = 32'h3300_0000;

    // top address byte decoded by the sram
    localparam logic [7:0] MEM_REGION = 8'h33;

    // sram geometry and timing
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW    = $clog2(SRAM_WORDS);
    localparam int SRAM_WAIT  = 2;              // strobe seen to ack
    localparam int WAIT_W     = $clog2(SRAM_WAIT + 1);

    // region / offset split of a bus address
    typedef struct packed {
        logic [7:0]  region;
        logic [23:0] offset;
    } bus_adr_s;

    // same 32 bits, seen either as one word or as region plus offset
    typedef union packed {
        logic [31:0] word;
        bus_adr_s    fields;
    } bus_adr_u;

endpackage

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // data and address width of the core
    localparam int XLEN = 32;

    // request unit states
    // each bus access goes idle -> wait_* -> mem/instr state -> idle
    typedef enum logic [2:0] {
        idle,
        wait_read,
        mem_read,
        wait_write,
        mem_write,
        wait_instr,
        instr_read
    } req_state_t;

endpackage
